//--- buffer_types_pkg.sv
`default_nettype none

package buffer_types_pkg;

  // Word width of the stream
  parameter int DEFAULT_DATA_WIDTH = 32;

  // Memory address width, depth is 2**ADDR_WIDTH
  // Kept small so full and empty are reached quickly
  parameter int DEFAULT_ADDR_WIDTH = 4;

  // Width of every size and length report
  parameter int SIZE_WIDTH = 24;

  // Word counts for free space, fill level and burst length
  typedef logic [SIZE_WIDTH-1:0] size_t;

endpackage

`default_nettype wire

//--- buffer_fsm_pkg.sv
`default_nettype none

package buffer_fsm_pkg;

  // Fill state of the buffer, drives both ready levels
  typedef enum logic [1:0] {
    FILL_EMPTY,
    FILL_PARTIAL,
    FILL_FULL
  } fill_state_t;

  // One activity period on either side
  typedef enum logic {
    BURST_IDLE,
    BURST_ACTIVE
  } burst_state_t;

endpackage

`default_nettype wire

//--- buffer_mem.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_mem #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  WR_CLK,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  rvalid
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge WR_CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, as in a block RAM
  always_ff @(posedge WR_CLK) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

  // Follows re, which the control block holds low during reset
  always_ff @(posedge WR_CLK) begin
    rvalid <= re;
  end

endmodule

`default_nettype wire

//--- buffer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_ctrl #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                    WR_CLK,
  input  logic                    r_rst,
  input  logic                    wr_act,
  input  logic                    wr_stb,
  input  logic                    rd_act,
  input  logic                    rd_stb,
  output logic                    wr_rdy,
  output logic                    rd_rdy,
  output logic                    wr_accept,
  output logic                    rd_accept,
  output logic [ADDR_WIDTH-1:0]   wr_ptr,
  output logic [ADDR_WIDTH-1:0]   rd_ptr,
  output buffer_types_pkg::size_t wr_space,
  output buffer_types_pkg::size_t rd_level
);

  import buffer_types_pkg::*;
  import buffer_fsm_pkg::*;

  // Count is one bit wider than the pointers so full fits
  localparam logic [ADDR_WIDTH:0] FULL_COUNT = {1'b1, {ADDR_WIDTH{1'b0}}};
  localparam logic [ADDR_WIDTH:0] LAST_COUNT = FULL_COUNT - 1'b1;

  fill_state_t         state;
  fill_state_t         state_next;
  logic [ADDR_WIDTH:0] count;

  assign wr_rdy = (state != FILL_FULL);
  assign rd_rdy = (state != FILL_EMPTY);

  assign wr_accept = wr_act & wr_stb & wr_rdy;
  assign rd_accept = rd_act & rd_stb & rd_rdy;

  always_comb begin
    state_next = state;
    case (state)
      FILL_EMPTY: begin
        if (wr_accept) begin
          state_next = FILL_PARTIAL;
        end
      end
      FILL_PARTIAL: begin
        if (wr_accept && !rd_accept && count == LAST_COUNT) begin
          state_next = FILL_FULL;
        end else if (rd_accept && !wr_accept && count == 1) begin
          state_next = FILL_EMPTY;
        end
      end
      FILL_FULL: begin
        // Writes are blocked while full
        if (rd_accept) begin
          state_next = FILL_PARTIAL;
        end
      end
      default: begin
        state_next = FILL_EMPTY;
      end
    endcase
  end

  always_ff @(posedge WR_CLK) begin
    if (r_rst) begin
      state  <= FILL_EMPTY;
      count  <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      state <= state_next;
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_accept && !rd_accept) begin
        count <= count + 1'b1;
      end else if (rd_accept && !wr_accept) begin
        count <= count - 1'b1;
      end
    end
  end

  assign rd_level = size_t'(count);
  assign wr_space = size_t'(FULL_COUNT - count);

endmodule

`default_nettype wire

//--- burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_counter (
  input  logic                    WR_CLK,
  input  logic                    r_rst,
  input  logic                    act,
  input  logic                    accept,
  output buffer_types_pkg::size_t burst_len,
  output logic                    burst_done
);

  import buffer_types_pkg::*;
  import buffer_fsm_pkg::*;

  burst_state_t state;
  size_t        count;

  always_ff @(posedge WR_CLK) begin
    if (r_rst) begin
      state      <= BURST_IDLE;
      count      <= '0;
      burst_len  <= '0;
      burst_done <= 1'b0;
    end else begin
      burst_done <= 1'b0;
      case (state)
        BURST_IDLE: begin
          if (act) begin
            state <= BURST_ACTIVE;
            // First word may land on the activating edge
            count <= size_t'(accept);
          end
        end
        BURST_ACTIVE: begin
          if (act) begin
            count <= count + size_t'(accept);
          end else begin
            // Period over, report even an empty one
            state      <= BURST_IDLE;
            burst_len  <= count;
            burst_done <= 1'b1;
          end
        end
        default: begin
          state <= BURST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- stream_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_top #(
  parameter int DATA_WIDTH = buffer_types_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = buffer_types_pkg::DEFAULT_ADDR_WIDTH
) (
  input  logic                    WR_CLK,
  input  logic                    r_rst,

  // Write side
  input  logic                    wr_act,
  input  logic                    wr_stb,
  input  logic [DATA_WIDTH-1:0]   wr_data,
  output logic                    wr_rdy,
  output buffer_types_pkg::size_t wr_space,
  output buffer_types_pkg::size_t wr_burst_len,
  output logic                    wr_burst_done,

  // Read side
  input  logic                    rd_act,
  input  logic                    rd_stb,
  output logic                    rd_rdy,
  output logic [DATA_WIDTH-1:0]   rd_data,
  output logic                    rd_valid,
  output buffer_types_pkg::size_t rd_level,
  output buffer_types_pkg::size_t rd_burst_len,
  output logic                    rd_burst_done
);

  logic                  wr_accept;
  logic                  rd_accept;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;

  buffer_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ctrl (
    .WR_CLK    (WR_CLK),
    .r_rst     (r_rst),
    .wr_act    (wr_act),
    .wr_stb    (wr_stb),
    .rd_act    (rd_act),
    .rd_stb    (rd_stb),
    .wr_rdy    (wr_rdy),
    .rd_rdy    (rd_rdy),
    .wr_accept (wr_accept),
    .rd_accept (rd_accept),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .wr_space  (wr_space),
    .rd_level  (rd_level)
  );

  buffer_mem #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mem (
    .WR_CLK (WR_CLK),
    .we     (wr_accept),
    .waddr  (wr_ptr),
    .wdata  (wr_data),
    .re     (rd_accept),
    .raddr  (rd_ptr),
    .rdata  (rd_data),
    .rvalid (rd_valid)
  );

  // Words moved per write activity period
  burst_counter u_wr_burst (
    .WR_CLK     (WR_CLK),
    .r_rst      (r_rst),
    .act        (wr_act),
    .accept     (wr_accept),
    .burst_len  (wr_burst_len),
    .burst_done (wr_burst_done)
  );

  // Words moved per read activity period
  burst_counter u_rd_burst (
    .WR_CLK     (WR_CLK),
    .r_rst      (r_rst),
    .act        (rd_act),
    .accept     (rd_accept),
    .burst_len  (rd_burst_len),
    .burst_done (rd_burst_done)
  );

endmodule

`default_nettype wire

//--- stream_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_tb;

  import buffer_types_pkg::*;

  localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
  localparam int ADDR_WIDTH = DEFAULT_ADDR_WIDTH;
  localparam int DEPTH      = 1 << ADDR_WIDTH;
  localparam int TIMEOUT    = 50;

  logic                  WR_CLK = 1'b0;
  logic                  r_rst;
  logic                  wr_act;
  logic                  wr_stb;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  wr_rdy;
  size_t                 wr_space;
  size_t                 wr_burst_len;
  logic                  wr_burst_done;
  logic                  rd_act;
  logic                  rd_stb;
  logic                  rd_rdy;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  size_t                 rd_level;
  size_t                 rd_burst_len;
  logic                  rd_burst_done;

  logic [31:0] lfsr;
  int          level_model;

  stream_buffer_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_stream_buffer_top (
    .WR_CLK        (WR_CLK),
    .r_rst         (r_rst),
    .wr_act        (wr_act),
    .wr_stb        (wr_stb),
    .wr_data       (wr_data),
    .wr_rdy        (wr_rdy),
    .wr_space      (wr_space),
    .wr_burst_len  (wr_burst_len),
    .wr_burst_done (wr_burst_done),
    .rd_act        (rd_act),
    .rd_stb        (rd_stb),
    .rd_rdy        (rd_rdy),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_level      (rd_level),
    .rd_burst_len  (rd_burst_len),
    .rd_burst_done (rd_burst_done)
  );

  always #50 WR_CLK = ~WR_CLK;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected));
    end
  endtask

  // Right-shift Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // Level and both ready flags against the model count
  task automatic check_levels();
    check_value("rd_level", rd_level, level_model);
    check_value("wr_space", wr_space, DEPTH - level_model);
    check_value("wr_rdy", wr_rdy, level_model != DEPTH);
    check_value("rd_rdy", rd_rdy, level_model != 0);
  endtask

  // No read in flight, so rd_valid must stay low
  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(negedge WR_CLK);
      check_value("rd_valid", rd_valid, 0);
    end
  endtask

  task automatic random_gap();
    int gap;
    int i;
    gap = 0;
    for (i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      gap = (gap << 1) | lfsr[0];
    end
    idle_cycles(gap);
  endtask

  task automatic wait_ready(input bit rd_side);
    int n;
    n = 0;
    while (rd_side ? !rd_rdy : !wr_rdy) begin
      if (n >= TIMEOUT) begin
        fail_run(rd_side ? "rd_rdy never went high" : "wr_rdy never went high");
      end else begin
        @(negedge WR_CLK);
        n++;
      end
    end
  endtask

  task automatic write_word(input logic [31:0] data);
    wait_ready(1'b0);
    wr_act  = 1'b1;
    wr_stb  = 1'b1;
    wr_data = data;
    @(posedge WR_CLK);
    @(negedge WR_CLK);
    wr_stb = 1'b0;
    level_model++;
    check_levels();
    random_gap();
  endtask

  task automatic read_word(input logic [31:0] expected);
    int lat;
    wait_ready(1'b1);
    rd_act = 1'b1;
    rd_stb = 1'b1;
    @(posedge WR_CLK);
    @(negedge WR_CLK);
    rd_stb = 1'b0;
    level_model--;
    lat = 1;
    while (!rd_valid) begin
      if (lat >= TIMEOUT) begin
        fail_run("rd_valid never went high after an accepted read");
      end else begin
        @(negedge WR_CLK);
        lat++;
      end
    end
    check_value("rd_valid latency", lat, 1);
    check_value("rd_data", rd_data, expected);
    check_levels();
    random_gap();
  endtask

  // Strobe against a full or empty side, nothing may move
  task automatic strobe_rejected(input bit rd_side, input logic [31:0] data);
    if (rd_side) begin
      check_value("rd_rdy", rd_rdy, 0);
      rd_act = 1'b1;
      rd_stb = 1'b1;
    end else begin
      check_value("wr_rdy", wr_rdy, 0);
      wr_act  = 1'b1;
      wr_stb  = 1'b1;
      wr_data = data;
    end
    @(posedge WR_CLK);
    @(negedge WR_CLK);
    rd_stb = 1'b0;
    wr_stb = 1'b0;
    check_value("rd_valid", rd_valid, 0);
    check_levels();
  endtask

  task automatic end_burst(input bit rd_side, input logic [31:0] expected);
    string side;
    int    n;
    logic  done;
    side = rd_side ? "rd" : "wr";
    // Empty period still needs one active edge
    if (rd_side ? !rd_act : !wr_act) begin
      if (rd_side) begin
        rd_act = 1'b1;
      end else begin
        wr_act = 1'b1;
      end
      @(negedge WR_CLK);
    end
    if (rd_side) begin
      rd_act = 1'b0;
    end else begin
      wr_act = 1'b0;
    end
    n    = 0;
    done = 1'b0;
    while (!done) begin
      if (n >= TIMEOUT) begin
        fail_run({side, "_burst_done never pulsed after the activity period"});
      end else begin
        @(negedge WR_CLK);
        n++;
        done = rd_side ? rd_burst_done : wr_burst_done;
      end
    end
    check_value({side, "_burst_len"}, rd_side ? rd_burst_len : wr_burst_len, expected);
    @(negedge WR_CLK);
    check_value({side, "_burst_done"}, rd_side ? rd_burst_done : wr_burst_done, 0);
  endtask

  task automatic run_command(input logic [63:0] op, input int count, input logic [31:0] value);
    int i;
    case (op)
      "WR": begin
        for (i = 0; i < count; i++) begin
          write_word(value + i);
        end
      end
      "RD": begin
        for (i = 0; i < count; i++) begin
          read_word(value + i);
        end
      end
      "WEND": end_burst(1'b0, value);
      "REND": end_burst(1'b1, value);
      "WX":   strobe_rejected(1'b0, value);
      "RX":   strobe_rejected(1'b1, value);
      "LVL": begin
        check_value("rd_level", rd_level, value);
        check_levels();
      end
      "IDLE": idle_cycles(count);
      default: fail_run("unknown opcode in the stimulus file");
    endcase
  endtask

  initial begin
    logic [8*128-1:0] line;
    logic [63:0]      op;
    int               count;
    logic [31:0]      value;
    int               fd;
    int               n;
    r_rst       = 1'b1;
    wr_act      = 1'b0;
    wr_stb      = 1'b0;
    wr_data     = '0;
    rd_act      = 1'b0;
    rd_stb      = 1'b0;
    lfsr        = 32'h7524_5c26;
    level_model = 0;
    repeat (8) @(negedge WR_CLK);
    r_rst = 1'b0;

    check_value("wr_rdy", wr_rdy, 1);
    check_value("rd_rdy", rd_rdy, 0);
    check_value("rd_valid", rd_valid, 0);
    check_value("wr_space", wr_space, DEPTH);
    check_value("rd_level", rd_level, 0);
    check_value("wr_burst_done", wr_burst_done, 0);
    check_value("rd_burst_done", rd_burst_done, 0);
    check_value("wr_burst_len", wr_burst_len, 0);
    check_value("rd_burst_len", rd_burst_len, 0);

    fd = $fopen("stream_buffer_stim.txt", "r");
    if (fd == 0) begin
      fail_run("could not open stream_buffer_stim.txt");
    end
    while ($fgets(line, fd) != 0) begin
      op = '0;
      n  = $sscanf(line, "%s %d %h", op, count, value);
      // Lines opening with a lone # are notes
      if (n >= 1 && op != "#") begin
        if (n != 3) begin
          fail_run("malformed line in the stimulus file");
        end else begin
          run_command(op, count, value);
        end
      end
    end
    $fclose(fd);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- stream_buffer_stim.txt
# opcode count value(hex)
# WR/RD move count words from value upward, WEND/REND expect a burst length
# LVL expects rd_level, IDLE waits count cycles, WX/RX strobe a full or empty side
LVL   0  0
WR    1  a0000001
WR    4  00001000
LVL   0  5
WEND  0  5
RD    1  a0000001
RD    4  00001000
REND  0  5
LVL   0  0
# empty buffer ignores a read strobe
RX    1  0
REND  0  0
# write period with no words
WEND  0  0
IDLE  3  0
# fill to the top across the pointer wrap
WR    8  00002000
WR    8  5a5a0010
LVL   0  10
WX    1  deadbeef
LVL   0  10
WEND  0  10
RD    1  00002000
LVL   0  f
WR    1  77770000
WEND  0  1
LVL   0  10
RD    7  00002001
RD    8  5a5a0010
RD    1  77770000
LVL   0  0
RX    1  0
REND  0  11
IDLE  4  0
# both sides active together
WR    3  0000c000
RD    2  0000c000
LVL   0  1
RD    1  0000c002
WEND  0  3
REND  0  3
LVL   0  0

//--- stream_buffer_top.f
buffer_types_pkg.sv
buffer_fsm_pkg.sv
buffer_mem.sv
buffer_ctrl.sv
burst_counter.sv
stream_buffer_top.sv
stream_buffer_tb.sv
